// ==== compile.f ====
+incdir+design
design/alu_isa_pkg.sv
design/alu_data_pkg.sv
design/alu_logic_unit.sv
design/alu_arith_unit.sv
design/alu_writeback_stage.sv
design/alu_top.sv
tests/tb_clock_gen.sv
tests/tb_alu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ALU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_alu_top -o sim_alu_top

./obj_dir/sim_alu_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
        exit 0
else
        exit 1
fi

// ==== tests/tb_alu_top.sv ====
`timescale 1ns/1ps

`include "alu_defs.svh"

module tb_alu_top;

        logic clk, reset, armed;
        logic clear, stall, shift_carry, rrx, flag_update;
        logic [31:0] rn, rm;
        logic [5:0] dest_index;
        alu_isa_pkg::alu_op_t op;
        alu_isa_pkg::cond_t cond;
        logic [31:0] result, branch_pc;
        logic dav, branch_valid;
        logic [5:0] dest_out;
        alu_data_pkg::flags_t flags;
        logic [31:0] exp_result, exp_branch_pc;
        logic exp_dav, exp_branch_valid;
        logic [5:0] exp_dest;
        logic [3:0] exp_flags;          // NZCV.
        logic [15:0] lfsr;
        int error_count, timeout_count, cycles;

        tb_clock_gen tb_clock_gen_i (.o_clk(clk), .o_reset(reset));

        alu_top alu_top_i (
                .i_clk(clk), .i_reset(reset), .i_clear(clear), .i_stall(stall),
                .i_rn(rn), .i_rm(rm), .i_shift_carry(shift_carry), .i_rrx(rrx),
                .i_opcode(op), .i_cond(cond), .i_flag_update(flag_update),
                .i_dest_index(dest_index), .o_result(result), .o_dav(dav),
                .o_dest_index(dest_out), .o_flags(flags),
                .o_branch_valid(branch_valid), .o_branch_pc(branch_pc)
        );

        // One LFSR step per bit handed out.
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                logic b;
                v = '0;
                for (int i = 0; i < n; i++)
                begin
                        b    = lfsr[0];
                        lfsr = lfsr >> 1;
                        if (b)
                                lfsr = lfsr ^ 16'hB400;
                        v = {v[30:0], b};
                end
                return v;
        endfunction

        function automatic logic [31:0] pick_operand();
                case (rand_bits(3))
                        32'd0: return 32'h0000_0000;
                        32'd1: return 32'hFFFF_FFFF;
                        32'd2: return 32'h8000_0000;
                        default: return rand_bits(32);
                endcase
        endfunction

        // Expected {NZCV, result} of one instruction.
        function automatic logic [35:0] ref_exec(input logic [31:0] a_rn, input logic [31:0] a_rm,
                                                 input logic [3:0] a_op, input logic [3:0] fl,
                                                 input logic a_rrx, input logic a_shc);
                logic [31:0] m, x, y, res;
                logic c, v, cin, bor;
                logic [63:0] u;
                logic signed [63:0] s;
                m   = a_rrx ? {fl[1], a_rm[31:1]} : a_rm;
                c   = a_rrx ? a_rm[0] : a_shc;
                v   = fl[0];
                res = '0;
                case (a_op)
                        4'd0, 4'd8: res = a_rn & m;
                        4'd1, 4'd9: res = a_rn ^ m;
                        4'd12: res = a_rn | m;
                        4'd13: res = m;
                        4'd14: res = a_rn & ~m;
                        4'd15: res = ~m;
                        default:
                        begin
                                x = (a_op == 4'd3 || a_op == 4'd7) ? m : a_rn; // Reverse forms.
                                y = (a_op == 4'd3 || a_op == 4'd7) ? a_rn : m;
                                if (a_op == 4'd4 || a_op == 4'd5 || a_op == 4'd11)
                                begin
                                        cin = (a_op == 4'd5) ? fl[1] : 1'b0;
                                        u   = {32'b0, x} + {32'b0, y} + {63'b0, cin};
                                        c   = u[32];
                                        s   = 64'($signed(x)) + 64'($signed(y)) + 64'(cin);
                                        res = x + y + {31'b0, cin};
                                end
                                else
                                begin
                                        bor = (a_op == 4'd6 || a_op == 4'd7) ? ~fl[1] : 1'b0;
                                        c   = ({32'b0, x} >= ({32'b0, y} + {63'b0, bor}));
                                        s   = 64'($signed(x)) - 64'($signed(y)) - 64'(bor);
                                        res = x - y - {31'b0, bor};
                                end
                                v = (s[63:31] != {33{s[31]}}); // Does not fit in 32 bits.
                        end
                endcase
                return {res[31], (res == 32'd0), c, v, res};
        endfunction

        function automatic logic cond_holds(input logic [3:0] cc, input logic [3:0] fl);
                case (cc)
                        4'd0: return fl[2];
                        4'd1: return !fl[2];
                        4'd2: return fl[1];
                        4'd3: return !fl[1];
                        4'd4: return fl[3];
                        4'd5: return !fl[3];
                        4'd6: return fl[0];
                        4'd7: return !fl[0];
                        4'd8: return fl[1] && !fl[2];
                        4'd9: return !fl[1] || fl[2];
                        4'd10: return fl[3] == fl[0];
                        4'd11: return fl[3] != fl[0];
                        4'd12: return !fl[2] && (fl[3] == fl[0]);
                        4'd13: return fl[2] || (fl[3] != fl[0]);
                        4'd14: return 1'b1;
                        default: return 1'b0;
                endcase
        endfunction

        // Reference model with one registered stage like the DUT.
        always @(posedge clk)
        begin : model
                logic [35:0] ex;
                logic ok, br;
                if (reset)
                begin
                        armed <= 1'b1;
                        {exp_result, exp_dav, exp_dest} <= '0;
                        {exp_branch_valid, exp_branch_pc, exp_flags} <= '0;
                end
                else if (clear)
                begin
                        {exp_result, exp_dav, exp_dest} <= '0;
                        {exp_branch_valid, exp_branch_pc} <= '0;
                end
                else if (!stall)
                begin
                        ex = ref_exec(rn, rm, 4'(op), exp_flags, rrx, shift_carry);
                        ok = cond_holds(4'(cond), exp_flags);
                        br = ok && dest_index == `ALU_IDX_W'(`ALU_PC_IDX) &&
                             !(4'(op) inside {4'd8, 4'd9, 4'd10, 4'd11});
                        exp_result       <= ex[31:0];
                        exp_dav          <= ok;
                        exp_dest         <= dest_index;
                        exp_branch_valid <= br;
                        exp_branch_pc    <= br ? ex[31:0] : 32'd0;
                        if (ok && flag_update)
                                exp_flags <= ex[35:32];
                end
        end

        task automatic report_mismatch(input string name, input logic [31:0] e,
                                       input logic [31:0] a);
                error_count++;
                $display("** Error at %0t: %s expected %h actual %h", $time, name, e, a);
        endtask

        a_result: assert property (@(posedge clk) disable iff (!armed) result == exp_result)
                else report_mismatch("o_result", $sampled(exp_result), $sampled(result));
        a_dav: assert property (@(posedge clk) disable iff (!armed) dav == exp_dav)
                else report_mismatch("o_dav", 32'($sampled(exp_dav)), 32'($sampled(dav)));
        a_dest: assert property (@(posedge clk) disable iff (!armed) dest_out == exp_dest)
                else report_mismatch("o_dest_index", 32'($sampled(exp_dest)),
                                     32'($sampled(dest_out)));
        a_flags: assert property (@(posedge clk) disable iff (!armed) flags == exp_flags)
                else report_mismatch("o_flags", 32'($sampled(exp_flags)), 32'($sampled(flags)));
        a_branch: assert property (@(posedge clk) disable iff (!armed)
                branch_valid == exp_branch_valid)
                else report_mismatch("o_branch_valid", 32'($sampled(exp_branch_valid)),
                                     32'($sampled(branch_valid)));
        a_branch_pc: assert property (@(posedge clk) disable iff (!armed)
                branch_pc == exp_branch_pc)
                else report_mismatch("o_branch_pc", $sampled(exp_branch_pc), $sampled(branch_pc));

        task automatic drive(input logic [3:0] o, input logic [3:0] cc, input logic fu,
                             input logic [5:0] d, input logic st, input logic cl);
                @(negedge clk);
                op          = alu_isa_pkg::alu_op_t'(o);
                cond        = alu_isa_pkg::cond_t'(cc);
                flag_update = fu;
                dest_index  = d;
                rn          = pick_operand();
                rm          = pick_operand();
                rrx         = rand_bits(1) == 32'd1;
                shift_carry = rand_bits(1) == 32'd1;
                stall       = st;
                clear       = cl;
        endtask

        initial
        begin
                lfsr = 16'd37619;
                armed = 1'b0;
                error_count = 0;
                timeout_count = 0;
                {clear, stall, shift_carry, rrx, flag_update, rn, rm, dest_index} = '0;
                op   = alu_isa_pkg::OP_AND;
                cond = alu_isa_pkg::CC_NV;

                cycles = 0;
                while (reset !== 1'b0 && cycles < 20)
                begin
                        @(posedge clk);
                        cycles++;
                end
                if (reset !== 1'b0)
                begin
                        timeout_count++;
                        $display("Reset was never released within 20 cycles.");
                        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
                        $display("Simulation finished: FAIL");
                        $finish;
                end
                else
                begin
                        repeat (3) drive(4'd0, 4'd15, 1'b1, 6'd1, 1'b0, 1'b0); // Bubbles.
                        for (int o = 0; o < 16; o++)
                                for (int k = 0; k < 8; k++)
                                        drive(4'(o), 4'd14, 1'b1, 6'd2, 1'b0, 1'b0);
                        for (int cc = 0; cc < 16; cc++)
                                for (int k = 0; k < 6; k++)
                                begin
                                        drive(4'(rand_bits(4)), 4'd14, 1'b1, 6'd3, 1'b0, 1'b0);
                                        drive(4'(rand_bits(4)), 4'(cc), 1'(rand_bits(1)), 6'd4,
                                              1'b0, 1'b0);
                                end
                        for (int o = 0; o < 16; o++)
                                drive(4'(o), 4'd14, 1'b0, 6'd15, 1'b0, 1'b0);
                        for (int k = 0; k < 200; k++)
                                drive(4'(rand_bits(4)), 4'(rand_bits(4)), 1'(rand_bits(1)),
                                      (rand_bits(2) == 32'd0) ? 6'd15 : 6'(rand_bits(6)),
                                      rand_bits(2) == 32'd0, rand_bits(3) == 32'd0);
                        repeat (2) drive(4'd0, 4'd15, 1'b0, 6'd0, 1'b0, 1'b0);
                        @(negedge clk);
                        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
                        if (error_count == 0 && timeout_count == 0)
                                $display("Simulation finished: PASS");
                        else
                                $display("Simulation finished: FAIL");
                        $finish;
                end
        end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
        output logic o_clk,
        output logic o_reset
);

        initial
        begin
                o_clk   = 1'b0;
                o_reset = 1'b1;
                forever #5 o_clk = ~o_clk;      // 10 ns period.
        end

        // Reset covers two rising edges and drops on a falling edge.
        initial
        begin
                repeat (2) @(posedge o_clk);
                @(negedge o_clk);
                o_reset = 1'b0;
        end

endmodule

// ==== design/alu_top.sv ====
`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_top
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear,
        input  logic                    i_stall,
        input  logic [`ALU_DATA_W-1:0]  i_rn,
        input  logic [`ALU_DATA_W-1:0]  i_rm,               // Shifted operand.
        input  logic                    i_shift_carry,
        input  logic                    i_rrx,
        input  alu_isa_pkg::alu_op_t    i_opcode,
        input  alu_isa_pkg::cond_t      i_cond,
        input  logic                    i_flag_update,
        input  logic [`ALU_IDX_W-1:0]   i_dest_index,
        output logic [`ALU_DATA_W-1:0]  o_result,
        output logic                    o_dav,
        output logic [`ALU_IDX_W-1:0]   o_dest_index,
        output alu_data_pkg::flags_t    o_flags,
        output logic                    o_branch_valid,
        output logic [`ALU_DATA_W-1:0]  o_branch_pc
);

        alu_data_pkg::unit_out_t logic_out;
        alu_data_pkg::unit_out_t arith_out;

        alu_logic_unit alu_logic_unit_i (
                .i_rn          (i_rn),
                .i_rm          (i_rm),
                .i_op          (i_opcode),
                .i_flags       (o_flags),       // Old carry for RRX.
                .i_rrx         (i_rrx),
                .i_shift_carry (i_shift_carry),
                .o_logic       (logic_out)
        );

        alu_arith_unit alu_arith_unit_i (
                .i_rn    (i_rn),
                .i_rm    (i_rm),
                .i_op    (i_opcode),
                .i_flags (o_flags),
                .i_rrx   (i_rrx),
                .o_arith (arith_out)
        );

        alu_writeback_stage alu_writeback_stage_i (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_clear        (i_clear),
                .i_stall        (i_stall),
                .i_op           (i_opcode),
                .i_cond         (i_cond),
                .i_flag_update  (i_flag_update),
                .i_dest_index   (i_dest_index),
                .i_logic        (logic_out),
                .i_arith        (arith_out),
                .o_result       (o_result),
                .o_dav          (o_dav),
                .o_dest_index   (o_dest_index),
                .o_flags        (o_flags),
                .o_branch_valid (o_branch_valid),
                .o_branch_pc    (o_branch_pc)
        );

endmodule

// ==== design/alu_writeback_stage.sv ====
`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_writeback_stage
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clear,        // Wins over stall.
        input  logic                    i_stall,
        input  alu_isa_pkg::alu_op_t    i_op,
        input  alu_isa_pkg::cond_t      i_cond,
        input  logic                    i_flag_update,
        input  logic [`ALU_IDX_W-1:0]   i_dest_index,
        input  alu_data_pkg::unit_out_t i_logic,
        input  alu_data_pkg::unit_out_t i_arith,
        output logic [`ALU_DATA_W-1:0]  o_result,
        output logic                    o_dav,
        output logic [`ALU_IDX_W-1:0]   o_dest_index,
        output alu_data_pkg::flags_t    o_flags,
        output logic                    o_branch_valid,
        output logic [`ALU_DATA_W-1:0]  o_branch_pc
);

        logic                    cond_ok;
        logic                    is_arith;
        logic                    is_compare;
        logic                    branch_nxt;
        alu_data_pkg::unit_out_t sel;

        // Condition check against the committed flags.
        always_comb
        begin
                case (i_cond)
                        alu_isa_pkg::CC_EQ: cond_ok = o_flags.z;
                        alu_isa_pkg::CC_NE: cond_ok = !o_flags.z;
                        alu_isa_pkg::CC_CS: cond_ok = o_flags.c;
                        alu_isa_pkg::CC_CC: cond_ok = !o_flags.c;
                        alu_isa_pkg::CC_MI: cond_ok = o_flags.n;
                        alu_isa_pkg::CC_PL: cond_ok = !o_flags.n;
                        alu_isa_pkg::CC_VS: cond_ok = o_flags.v;
                        alu_isa_pkg::CC_VC: cond_ok = !o_flags.v;
                        alu_isa_pkg::CC_HI: cond_ok = o_flags.c && !o_flags.z;
                        alu_isa_pkg::CC_LS: cond_ok = !o_flags.c || o_flags.z;
                        alu_isa_pkg::CC_GE: cond_ok = (o_flags.n == o_flags.v);
                        alu_isa_pkg::CC_LT: cond_ok = (o_flags.n != o_flags.v);
                        alu_isa_pkg::CC_GT: cond_ok = !o_flags.z && (o_flags.n == o_flags.v);
                        alu_isa_pkg::CC_LE: cond_ok = o_flags.z || (o_flags.n != o_flags.v);
                        alu_isa_pkg::CC_AL: cond_ok = 1'b1;
                        default:            cond_ok = 1'b0; // NV bubble.
                endcase
        end

        assign is_arith = (i_op inside {alu_isa_pkg::OP_SUB, alu_isa_pkg::OP_RSB,
                                        alu_isa_pkg::OP_ADD, alu_isa_pkg::OP_ADC,
                                        alu_isa_pkg::OP_SBC, alu_isa_pkg::OP_RSC,
                                        alu_isa_pkg::OP_CMP, alu_isa_pkg::OP_CMN});

        assign is_compare = (i_op inside {alu_isa_pkg::OP_TST, alu_isa_pkg::OP_TEQ,
                                          alu_isa_pkg::OP_CMP, alu_isa_pkg::OP_CMN});

        assign sel = is_arith ? i_arith : i_logic;

        // A committed write to PC redirects fetch.
        assign branch_nxt = cond_ok && !is_compare &&
                            (i_dest_index == `ALU_IDX_W'(`ALU_PC_IDX));

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_result       <= '0;
                        o_dav          <= 1'b0;
                        o_dest_index   <= '0;
                        o_flags        <= '0;
                        o_branch_valid <= 1'b0;
                        o_branch_pc    <= '0;
                end
                else if (i_clear)
                begin
                        o_result       <= '0; // Flags survive a flush.
                        o_dav          <= 1'b0;
                        o_dest_index   <= '0;
                        o_branch_valid <= 1'b0;
                        o_branch_pc    <= '0;
                end
                else if (!i_stall)
                begin
                        o_result       <= sel.result;
                        o_dav          <= cond_ok;
                        o_dest_index   <= i_dest_index;
                        o_branch_valid <= branch_nxt;
                        o_branch_pc    <= branch_nxt ? sel.result : '0;
                        if (cond_ok && i_flag_update)
                        begin
                                o_flags <= sel.flags;
                        end
                end
        end

        a_branch_has_dav: assert property (@(posedge i_clk) disable iff (i_reset)
                o_branch_valid |-> o_dav);

        // Nothing leaves the stage the cycle after a flush.
        a_clear_kills_dav: assert property (@(posedge i_clk) disable iff (i_reset)
                i_clear |=> !o_dav);

        a_stall_holds_flags: assert property (@(posedge i_clk) disable iff (i_reset)
                i_stall |=> $stable(o_flags));

endmodule

// ==== design/alu_arith_unit.sv ====
`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_arith_unit
(
        input  logic [`ALU_DATA_W-1:0]  i_rn,
        input  logic [`ALU_DATA_W-1:0]  i_rm,
        input  alu_isa_pkg::alu_op_t    i_op,
        input  alu_data_pkg::flags_t    i_flags,
        input  logic                    i_rrx,
        output alu_data_pkg::unit_out_t o_arith
);

        logic [`ALU_DATA_W-1:0] rm_eff;
        logic [`ALU_DATA_W-1:0] op_a;
        logic [`ALU_DATA_W-1:0] op_b;
        logic                   carry_in;
        logic                   is_arith;
        logic [`ALU_DATA_W:0]   sum;            // Bit 32 is carry out.

        // RRX only reshapes the operand here.
        assign rm_eff = i_rrx ? {i_flags.c, i_rm[`ALU_DATA_W-1:1]} : i_rm;

        // Subtract is a + ~b + 1, so carry out means no borrow.
        always_comb
        begin
                is_arith = 1'b1;
                op_a     = i_rn;
                op_b     = rm_eff;
                carry_in = 1'b0;

                case (i_op)
                        alu_isa_pkg::OP_ADD,
                        alu_isa_pkg::OP_CMN: carry_in = 1'b0;
                        alu_isa_pkg::OP_ADC: carry_in = i_flags.c;
                        alu_isa_pkg::OP_SUB,
                        alu_isa_pkg::OP_CMP:
                        begin
                                op_b     = ~rm_eff;
                                carry_in = 1'b1;
                        end
                        alu_isa_pkg::OP_SBC:
                        begin
                                op_b     = ~rm_eff;
                                carry_in = i_flags.c; // Minus not-C.
                        end
                        alu_isa_pkg::OP_RSB:
                        begin
                                op_a     = rm_eff;
                                op_b     = ~i_rn;
                                carry_in = 1'b1;
                        end
                        alu_isa_pkg::OP_RSC:
                        begin
                                op_a     = rm_eff;
                                op_b     = ~i_rn;
                                carry_in = i_flags.c;
                        end
                        default:
                        begin
                                is_arith = 1'b0;
                                op_a     = '0;
                                op_b     = '0;
                        end
                endcase

                assert (carry_in == 1'b0 || carry_in == 1'b1)
                        else $error("arith unit carry-in is unknown");
        end

        assign sum = {1'b0, op_a} + {1'b0, op_b} + {{`ALU_DATA_W{1'b0}}, carry_in};

        always_comb
        begin
                if (is_arith)
                begin
                        o_arith.result  = sum[`ALU_DATA_W-1:0];
                        o_arith.flags.n = sum[`ALU_DATA_W-1];
                        o_arith.flags.z = (sum[`ALU_DATA_W-1:0] == '0);
                        o_arith.flags.c = sum[`ALU_DATA_W];
                        // Like-signed inputs giving an unlike-signed sum.
                        o_arith.flags.v = (op_a[`ALU_DATA_W-1] == op_b[`ALU_DATA_W-1]) &&
                                          (sum[`ALU_DATA_W-1] != op_a[`ALU_DATA_W-1]);
                end
                else
                begin
                        o_arith = '0;
                end
        end

endmodule

// ==== design/alu_logic_unit.sv ====
`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_logic_unit
(
        input  logic [`ALU_DATA_W-1:0]  i_rn,
        input  logic [`ALU_DATA_W-1:0]  i_rm,
        input  alu_isa_pkg::alu_op_t    i_op,
        input  alu_data_pkg::flags_t    i_flags,        // Current flags.
        input  logic                    i_rrx,
        input  logic                    i_shift_carry,  // Carry out of the shifter.
        output alu_data_pkg::unit_out_t o_logic
);

        logic [`ALU_DATA_W-1:0] rm_eff;
        logic [`ALU_DATA_W-1:0] result;
        logic                   carry_out;
        logic                   is_logic;

        // RRX rotates the old carry in at the top and drops bit 0.
        always_comb
        begin
                if (i_rrx)
                begin
                        rm_eff    = {i_flags.c, i_rm[`ALU_DATA_W-1:1]};
                        carry_out = i_rm[0];
                end
                else
                begin
                        rm_eff    = i_rm;
                        carry_out = i_shift_carry;
                end
        end

        always_comb
        begin
                is_logic = 1'b1;
                result   = '0;

                case (i_op)
                        alu_isa_pkg::OP_AND,
                        alu_isa_pkg::OP_TST: result = i_rn & rm_eff;
                        alu_isa_pkg::OP_EOR,
                        alu_isa_pkg::OP_TEQ: result = i_rn ^ rm_eff;
                        alu_isa_pkg::OP_ORR: result = i_rn | rm_eff;
                        alu_isa_pkg::OP_MOV: result = rm_eff;
                        alu_isa_pkg::OP_BIC: result = i_rn & ~rm_eff;
                        alu_isa_pkg::OP_MVN: result = ~rm_eff;
                        default:             is_logic = 1'b0;
                endcase
        end

        // Logical class leaves V alone.
        always_comb
        begin
                if (is_logic)
                begin
                        o_logic.result  = result;
                        o_logic.flags.n = result[`ALU_DATA_W-1];
                        o_logic.flags.z = (result == '0);
                        o_logic.flags.c = carry_out;
                        o_logic.flags.v = i_flags.v;
                end
                else
                begin
                        o_logic = '0; // Not our opcode.
                end
        end

endmodule

// ==== design/alu_data_pkg.sv ====
`include "alu_defs.svh"

package alu_data_pkg;

        // Condition flags in NZCV order from the MSB down.
        typedef struct packed {
                logic n;        // Negative.
                logic z;        // Zero.
                logic c;        // Carry, or no borrow on subtract.
                logic v;        // Signed overflow.
        } flags_t;

        // What each execution unit hands to writeback.
        // Candidate flags sit above the result word.
        typedef struct packed {
                flags_t                 flags;
                logic [`ALU_DATA_W-1:0] result;
        } unit_out_t;

endpackage

// ==== design/alu_isa_pkg.sv ====
`include "alu_defs.svh"

package alu_isa_pkg;

        // Data-processing opcodes in instruction encoding order.
        typedef enum logic [3:0] {
                OP_AND = 4'd0,
                OP_EOR = 4'd1,
                OP_SUB = 4'd2,
                OP_RSB = 4'd3,
                OP_ADD = 4'd4,
                OP_ADC = 4'd5,
                OP_SBC = 4'd6,
                OP_RSC = 4'd7,
                OP_TST = 4'd8,  // Flags only.
                OP_TEQ = 4'd9,  // Flags only.
                OP_CMP = 4'd10, // Flags only.
                OP_CMN = 4'd11, // Flags only.
                OP_ORR = 4'd12,
                OP_MOV = 4'd13,
                OP_BIC = 4'd14,
                OP_MVN = 4'd15
        } alu_op_t;

        // Condition field taken from bits 31:28 of the instruction.
        typedef enum logic [3:0] {
                CC_EQ = 4'd0,
                CC_NE = 4'd1,
                CC_CS = 4'd2,
                CC_CC = 4'd3,
                CC_MI = 4'd4,
                CC_PL = 4'd5,
                CC_VS = 4'd6,
                CC_VC = 4'd7,
                CC_HI = 4'd8,
                CC_LS = 4'd9,
                CC_GE = 4'd10,
                CC_LT = 4'd11,
                CC_GT = 4'd12,
                CC_LE = 4'd13,
                CC_AL = 4'd14,
                CC_NV = 4'd15   // Never. Used as the pipeline bubble.
        } cond_t;

endpackage

// ==== design/alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Datapath width of the execute stage.
`define ALU_DATA_W 32

// Register index width.
// Six bits cover all 46 physical registers.
`define ALU_IDX_W 6

// Physical index of the program counter.
`define ALU_PC_IDX 15

`endif
